//--- flist.f
+incdir+.
texCacheAddrPkg.sv
texCacheDataPkg.sv
texLineStore.sv
lineValidTable.sv
texelLookup.sv
texCacheTop.sv
tb_texCache.sv

//--- lineValidTable.sv
// per-line valid bits of the texel cache with bulk clear and two write-first lookups
`include "texCache_defines.svh"

module lineValidTable (
	input logic clk,
	input logic reset, // same effect as clearCache
	input logic clearCache, // level, drops every line on each edge it is high
	input logic write,
	input texCacheAddrPkg::lineIndex_t writeIndex, // already swizzled
	input texCacheAddrPkg::lineIndex_t lookIndexA,
	input texCacheAddrPkg::lineIndex_t lookIndexB,
	output logic validA, // aligned with lineA / tagA
	output logic validB
);

	localparam int unsigned LINES = 1 << `TC_INDEX_BITS;

	logic [LINES-1:0] validBits;
	logic clearing;
	logic setA; // write makes port A's line valid this edge
	logic setB;

	assign clearing = reset || clearCache;
	assign setA = write && (writeIndex == lookIndexA);
	assign setB = write && (writeIndex == lookIndexB);

	// clear beats a write on the same edge
	always_ff @(posedge clk) begin
		if (clearing) begin
			validBits <= '0;
		end else if (write) begin
			validBits[writeIndex] <= 1'b1;
		end
	end

	// lookups see the table as it is after this edge
	always_ff @(posedge clk) begin
		if (clearing) begin
			validA <= 1'b0;
			validB <= 1'b0;
		end else begin
			validA <= validBits[lookIndexA] || setA;
			validB <= validBits[lookIndexB] || setB;
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the texel cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f flist.f --top-module tb_texCache -Mdir obj_dir \
	&& ./obj_dir/Vtb_texCache | tee /dev/stderr | grep -x "test passed" > /dev/null \
	&& exit 0 \
	|| exit 1

//--- tb_texCache.sv
// testbench of the texel cache: random writes and lookups on both ports against a line model
`include "texCache_defines.svh"

module tb_texCache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 40; // lookups only, nothing written yet
	localparam int RAND_CYCLES = 4000;
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RAND_CYCLES;
	localparam int TIMEOUT_NS = (TOTAL_CYCLES + 50) * PERIOD;
	localparam int LINES = 1 << `TC_INDEX_BITS;
	localparam int RECENT_MAX = 24; // how many written lines lookups aim at

	logic clk;
	logic reset;
	logic clearCache;
	logic textureFormatTrueColor;
	logic write;
	texCacheAddrPkg::texAddr_t writeAddr;
	texCacheDataPkg::line_t writeData;
	texCacheAddrPkg::texAddr_t lookAddrA;
	texCacheAddrPkg::texAddr_t lookAddrB;
	texCacheDataPkg::texel_t texelA;
	texCacheDataPkg::texel_t texelB;
	logic hitA;
	logic hitB;

	// reference model of the cache contents
	texCacheAddrPkg::lineTag_t modelTag [0:LINES-1];
	texCacheDataPkg::line_t modelLine [0:LINES-1];
	logic modelValid [0:LINES-1];
	texCacheAddrPkg::texAddr_t recent [$]; // cache-space addresses of latest writes
	int errors;
	int hitsSeen; // lookups where the model expects a hit
	int cycle;

	texCacheTop i_texCacheTop (
		.clk(clk),
		.reset(reset),
		.clearCache(clearCache),
		.textureFormatTrueColor(textureFormatTrueColor),
		.write(write),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.lookAddrA(lookAddrA),
		.lookAddrB(lookAddrB),
		.texelA(texelA),
		.texelB(texelB),
		.hitA(hitA),
		.hitB(hitB)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// vram address to cache address
	// each format swaps two fields of equal width, so applying it twice gives the input back
	function automatic texCacheAddrPkg::texAddr_t swizzle(texCacheAddrPkg::texAddr_t a,
		logic trueColor);
		texCacheAddrPkg::texAddr_t c;
		if (trueColor) begin
			c = {a[19:16], a[10:6], a[15:11], a[5:0]}; // 5-bit row and column fields swap
		end else begin
			c = {a[19:17], a[10:5], a[16:11], a[4:0]}; // 6-bit fields here
		end
		return c;
	endfunction

	function automatic texCacheAddrPkg::lineIndex_t indexOf(texCacheAddrPkg::texAddr_t c);
		return c[`TC_OFFSET_BITS +: `TC_INDEX_BITS];
	endfunction

	function automatic texCacheAddrPkg::lineTag_t tagOf(texCacheAddrPkg::texAddr_t c);
		return c[`TC_ADDR_BITS-1 -: `TC_TAG_BITS]; // cache-address bits 19..11
	endfunction

	function automatic texCacheAddrPkg::texAddr_t randomAddr();
		logic [31:0] r;
		r = $urandom();
		return r[`TC_ADDR_BITS-1:0];
	endfunction

	// mostly a recently written line, sometimes the line written this cycle, a few random
	function automatic texCacheAddrPkg::texAddr_t pickLook(logic writing,
		texCacheAddrPkg::texAddr_t writeCache);
		texCacheAddrPkg::texAddr_t a;
		texCacheAddrPkg::texAddr_t low;
		int unsigned sel;
		sel = $urandom_range(99);
		low = randomAddr();
		if (sel < 15 || recent.size() == 0) begin
			a = randomAddr();
		end else if (sel < 35 && writing) begin
			a = writeCache; // same edge as the write
		end else begin
			a = recent[$urandom_range(recent.size() - 1)];
		end
		a[`TC_OFFSET_BITS-1:0] = low[`TC_OFFSET_BITS-1:0]; // any texel of the line
		return a;
	endfunction

	// apply what the DUT saw on this edge: clear beats write, data is stored anyway
	task automatic updateModel();
		texCacheAddrPkg::texAddr_t c;
		c = swizzle(writeAddr, textureFormatTrueColor);
		if (write) begin
			modelTag[indexOf(c)] = tagOf(c);
			modelLine[indexOf(c)] = writeData;
		end
		if (reset || clearCache) begin
			for (int i = 0; i < LINES; i++) begin
				modelValid[i] = 1'b0;
			end
		end else if (write) begin
			modelValid[indexOf(c)] = 1'b1;
		end
	endtask

	// compare one port's result with the model state after this edge
	task automatic checkPort(string name, texCacheAddrPkg::texAddr_t look, logic hit,
		texCacheDataPkg::texel_t texel);
		texCacheAddrPkg::lineIndex_t idx;
		texCacheDataPkg::line_t ln;
		texCacheDataPkg::texel_t expTexel;
		logic expHit;
		idx = indexOf(look);
		ln = modelLine[idx];
		expHit = modelValid[idx] && (modelTag[idx] == tagOf(look));
		case (look[2:1]) // word 0 at the low end of the line
			2'd0: expTexel = ln[15:0];
			2'd1: expTexel = ln[31:16];
			2'd2: expTexel = ln[47:32];
			default: expTexel = ln[63:48];
		endcase
		assert (hit === expHit) else begin
			errors++;
			$display("CHECK FAILED hit%s: got %h expected %h (look %h)", name, hit, expHit, look);
		end
		if (expHit) begin
			hitsSeen++;
			assert (texel === expTexel) else begin
				errors++;
				$display("CHECK FAILED texel%s: got %h expected %h (look %h)", name, texel,
					expTexel, look);
			end
		end
	endtask

	// next cycle's inputs, driven just after the edge
	task automatic driveInputs();
		texCacheAddrPkg::texAddr_t c;
		texCacheAddrPkg::texAddr_t cw;
		logic [31:0] r;
		logic writesOn;
		writesOn = (cycle >= RESET_CYCLES + IDLE_CYCLES);
		write = 1'b0;
		clearCache = 1'b0;
		textureFormatTrueColor = ($urandom_range(1) == 1);
		writeAddr = randomAddr();
		writeData = {$urandom(), $urandom()};
		if (writesOn) begin
			write = ($urandom_range(99) < 40);
			clearCache = ($urandom_range(199) == 0);
			if (cycle % 500 == 250) begin
				write = 1'b1; // clear and write on one edge, line must stay invalid
				clearCache = 1'b1;
			end
			if (write && recent.size() > 0 && $urandom_range(1) == 1) begin
				c = recent[$urandom_range(recent.size() - 1)];
				if ($urandom_range(1) == 1) begin
					r = $urandom();
					c[`TC_ADDR_BITS-1 -: `TC_TAG_BITS] = tagOf(c) ^
						{r[`TC_TAG_BITS-1:1], 1'b1}; // same index, other tag
				end
				writeAddr = swizzle(c, textureFormatTrueColor); // back to vram space
			end
		end
		cw = swizzle(writeAddr, textureFormatTrueColor);
		lookAddrA = pickLook(write, cw);
		if ($urandom_range(3) == 0) begin
			lookAddrB = lookAddrA; // both ports on one address
		end else begin
			lookAddrB = pickLook(write, cw);
		end
		if (write) begin
			recent.push_back(cw);
			if (recent.size() > RECENT_MAX) begin
				void'(recent.pop_front());
			end
		end
	endtask

	initial begin
		void'($urandom(32'h3b22_fec5));
		errors = 0;
		hitsSeen = 0;
		reset = 1'b1;
		clearCache = 1'b0;
		textureFormatTrueColor = 1'b0;
		write = 1'b0;
		writeAddr = '0;
		writeData = '0;
		lookAddrA = '0;
		lookAddrB = '0;
		for (cycle = 0; cycle < TOTAL_CYCLES; cycle++) begin
			@(posedge clk);
			#2;
			updateModel(); // outputs now show the lookups of this edge
			checkPort("A", lookAddrA, hitA, texelA);
			checkPort("B", lookAddrB, hitB, texelB);
			reset = (cycle + 1 < RESET_CYCLES);
			driveInputs();
		end
		assert (hitsSeen > 100) else begin
			errors++;
			$display("too few lookups hit the cache to exercise the texel path");
		end
		$display("errors: %0d, hits checked: %0d", errors, hitsSeen);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog, a little longer than all test cycles
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("test failed");
		$finish;
	end

endmodule

//--- texCacheAddrPkg.sv
// address-field types of the texel cache: byte address, line index, tag, word select
`include "texCache_defines.svh"

package texCacheAddrPkg;

	// full byte address, in vram or in swizzled cache space
	typedef logic [`TC_ADDR_BITS-1:0] texAddr_t;

	// selects one of the direct-mapped lines
	typedef logic [`TC_INDEX_BITS-1:0] lineIndex_t;

	// upper cache-address bits kept next to the data
	typedef logic [`TC_TAG_BITS-1:0] lineTag_t;

	// texel inside a line, from address bits 2..1
	// bit 0 is the byte inside a 16-bit texel and is never looked at
	typedef logic [`TC_OFFSET_BITS-2:0] wordSel_t;

endpackage

//--- texCacheDataPkg.sv
// data types of the texel cache: line, texel and the stored tag+line entry
`include "texCache_defines.svh"

package texCacheDataPkg;

	// one cache line, four texels, texel 0 in the low bits
	typedef logic [`TC_LINE_BITS-1:0] line_t;

	// single 16-bit texel
	typedef logic [`TC_TEXEL_BITS-1:0] texel_t;

	// what one RAM word holds
	// tag on top so a dump reads tag first
	typedef struct packed {
		texCacheAddrPkg::lineTag_t tag; // swizzled address bits above the index
		line_t data; // the 64-bit write as it came in
	} entry_t;

endpackage

//--- texCacheTop.sv
// direct-mapped texel cache with one snooping write port and two read ports
`include "texCache_defines.svh"

module texCacheTop (
	input logic clk,
	input logic reset,
	input logic clearCache, // level, invalidates everything
	input logic textureFormatTrueColor, // picks the write swizzle
	input logic write, // 64-bit atomic write seen on the vram bus
	input texCacheAddrPkg::texAddr_t writeAddr, // vram byte address
	input texCacheDataPkg::line_t writeData,
	input texCacheAddrPkg::texAddr_t lookAddrA, // cache-space address
	input texCacheAddrPkg::texAddr_t lookAddrB,
	output texCacheDataPkg::texel_t texelA, // one cycle after lookAddrA
	output texCacheDataPkg::texel_t texelB,
	output logic hitA,
	output logic hitB
);

	texCacheAddrPkg::lineIndex_t lookIndexA;
	texCacheAddrPkg::lineIndex_t lookIndexB;
	texCacheAddrPkg::lineIndex_t writeIndex; // swizzled write line
	texCacheDataPkg::line_t lineA;
	texCacheDataPkg::line_t lineB;
	texCacheAddrPkg::lineTag_t tagA;
	texCacheAddrPkg::lineTag_t tagB;
	logic validA;
	logic validB;

	// line index sits just above the byte offset
	assign lookIndexA = lookAddrA[`TC_OFFSET_BITS +: `TC_INDEX_BITS];
	assign lookIndexB = lookAddrB[`TC_OFFSET_BITS +: `TC_INDEX_BITS];

	texLineStore lineStore (
		.clk(clk),
		.write(write),
		.textureFormatTrueColor(textureFormatTrueColor),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.lookIndexA(lookIndexA),
		.lookIndexB(lookIndexB),
		.writeIndex(writeIndex),
		.writeTag(), // only the store itself needs the write tag
		.lineA(lineA),
		.lineB(lineB),
		.tagA(tagA),
		.tagB(tagB)
	);

	lineValidTable validTable (
		.clk(clk),
		.reset(reset),
		.clearCache(clearCache),
		.write(write),
		.writeIndex(writeIndex),
		.lookIndexA(lookIndexA),
		.lookIndexB(lookIndexB),
		.validA(validA),
		.validB(validB)
	);

	texelLookup texelLookupA (
		.clk(clk),
		.lookAddr(lookAddrA),
		.line(lineA),
		.storedTag(tagA),
		.valid(validA),
		.texel(texelA),
		.hit(hitA)
	);

	// port B is fully independent of A
	texelLookup texelLookupB (
		.clk(clk),
		.lookAddr(lookAddrB),
		.line(lineB),
		.storedTag(tagB),
		.valid(validB),
		.texel(texelB),
		.hit(hitB)
	);

endmodule

//--- texCache_defines.svh
// texel cache widths: byte address, line index, line, texel and the derived tag
`ifndef TEX_CACHE_DEFINES_SVH
`define TEX_CACHE_DEFINES_SVH

// 1 MB video memory, byte addressed
`define TC_ADDR_BITS 20

// 8 -> 256 lines (2 KB), 9 -> 512 lines (4 KB)
`define TC_INDEX_BITS 8

`define TC_LINE_BITS 64 // one atomic write fills one line
`define TC_TEXEL_BITS 16 // texel handed to the rasterizer
`define TC_OFFSET_BITS 3 // byte offset inside a 64-bit line

// what is left above index and offset is the tag
`define TC_TAG_BITS (`TC_ADDR_BITS - `TC_INDEX_BITS - `TC_OFFSET_BITS)

`endif

//--- texLineStore.sv
// tag+line RAM of the texel cache: swizzles snooped writes and serves two registered reads
`include "texCache_defines.svh"

module texLineStore (
	input logic clk,
	input logic write, // one-cycle strobe, whole line
	input logic textureFormatTrueColor, // sampled with the write
	input texCacheAddrPkg::texAddr_t writeAddr, // vram byte address
	input texCacheDataPkg::line_t writeData,
	input texCacheAddrPkg::lineIndex_t lookIndexA,
	input texCacheAddrPkg::lineIndex_t lookIndexB,
	output texCacheAddrPkg::lineIndex_t writeIndex, // swizzled, for the valid table
	output texCacheAddrPkg::lineTag_t writeTag,
	output texCacheDataPkg::line_t lineA,
	output texCacheDataPkg::line_t lineB,
	output texCacheAddrPkg::lineTag_t tagA,
	output texCacheAddrPkg::lineTag_t tagB
);

	localparam int unsigned LINES = 1 << `TC_INDEX_BITS;

	texCacheAddrPkg::texAddr_t swizzled; // write address in cache space
	texCacheDataPkg::entry_t newEntry; // what the write stores
	texCacheDataPkg::entry_t lineMem [0:LINES-1];
	texCacheDataPkg::entry_t entryA; // read registers, one per port
	texCacheDataPkg::entry_t entryB;
	logic bypassA; // write lands on the line port A reads
	logic bypassB;

	// fold a block of texture rows into consecutive lines
	// true colour: 4 page bits, 5 row bits, 5 column bits, 6 low bits
	// 8/4 bpp: 3 page bits, 6 row bits, 6 column bits, 5 low bits
	always_comb begin
		if (textureFormatTrueColor) begin
			swizzled = {writeAddr[19:16], writeAddr[10:6], writeAddr[15:11], writeAddr[5:0]};
		end else begin
			swizzled = {writeAddr[19:17], writeAddr[10:5], writeAddr[16:11], writeAddr[4:0]};
		end
	end

	// split the cache address, offset bits dropped
	assign writeIndex = swizzled[`TC_OFFSET_BITS +: `TC_INDEX_BITS];
	assign writeTag = swizzled[`TC_ADDR_BITS-1 -: `TC_TAG_BITS];

	assign newEntry.tag = writeTag;
	assign newEntry.data = writeData;

	// same-edge hit on the written line means the read must see the new entry
	assign bypassA = write && (writeIndex == lookIndexA);
	assign bypassB = write && (writeIndex == lookIndexB);

	// single write port, always a full line
	always_ff @(posedge clk) begin
		if (write) begin
			lineMem[writeIndex] <= newEntry;
		end
	end

	// write-first reads, one cycle latency on both ports
	always_ff @(posedge clk) begin
		if (bypassA) begin
			entryA <= newEntry; // forwarded
		end else begin
			entryA <= lineMem[lookIndexA];
		end
		if (bypassB) begin
			entryB <= newEntry;
		end else begin
			entryB <= lineMem[lookIndexB];
		end
	end

	assign lineA = entryA.data;
	assign tagA = entryA.tag; // compared against the look tag downstream
	assign lineB = entryB.data;
	assign tagB = entryB.tag;

endmodule

//--- texelLookup.sv
// one read port of the texel cache: tag compare and texel select on the registered line
`include "texCache_defines.svh"

module texelLookup (
	input logic clk,
	input texCacheAddrPkg::texAddr_t lookAddr, // cache-space address, sampled each edge
	input texCacheDataPkg::line_t line, // registered line from the store
	input texCacheAddrPkg::lineTag_t storedTag, // tag that came with it
	input logic valid, // registered valid bit for the same index
	output texCacheDataPkg::texel_t texel,
	output logic hit
);

	texCacheAddrPkg::lineTag_t lookTag; // look tag, one cycle late like the line
	texCacheAddrPkg::wordSel_t wordSel;

	// index went to the RAM this edge, keep the rest for the next cycle
	always_ff @(posedge clk) begin
		lookTag <= lookAddr[`TC_ADDR_BITS-1 -: `TC_TAG_BITS];
		wordSel <= lookAddr[1 +: (`TC_OFFSET_BITS-1)]; // bits 2..1
	end

	// a stale tag on a valid line is a miss
	assign hit = valid && (storedTag == lookTag);

	// word 0 sits at the bottom of the line
	assign texel = line[wordSel*`TC_TEXEL_BITS +: `TC_TEXEL_BITS];

endmodule
